/* flist.f */
hdl/c2d_pkg.sv
hdl/c2d_fifo.sv
hdl/c2d_startup.sv
hdl/c2d_pixel2byte.sv
hdl/c2d_pkt_formatter.sv
hdl/c2d_lane_ctrl.sv
hdl/c2d_top.sv
tests/c2d_properties.sv
tests/c2d_tb.sv

/* hdl/c2d_fifo.sv */
`timescale 1ns/1ps

module c2d_fifo #(
  parameter type payload_t = c2d_pkg::word_t
) (
  input  logic     core_clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  payload_t mem [c2d_pkg::FIFO_DEPTH];

  // Extra top bit tells full from empty
  logic [c2d_pkg::FIFO_AW:0] wr_ptr_q;
  logic [c2d_pkg::FIFO_AW:0] rd_ptr_q;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[c2d_pkg::FIFO_AW] != rd_ptr_q[c2d_pkg::FIFO_AW]) &&
                   (wr_ptr_q[c2d_pkg::FIFO_AW-1:0] == rd_ptr_q[c2d_pkg::FIFO_AW-1:0]);

  assign data_o = mem[rd_ptr_q[c2d_pkg::FIFO_AW-1:0]];  // Head visible without a pop

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i && !full_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i && !empty_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge core_clk_i) begin
    if (push_i && !full_o) begin
      mem[wr_ptr_q[c2d_pkg::FIFO_AW-1:0]] <= data_i;
    end
  end

endmodule

/* hdl/c2d_lane_ctrl.sv */
`timescale 1ns/1ps

module c2d_lane_ctrl (
  input  logic           core_clk_i,
  input  logic           rst_n_i,
  input  logic           hs_req_i,
  output logic           hs_ack_o,
  input  c2d_pkg::word_t pkt_word_i,
  output logic           lp_p_o,
  output logic           lp_n_o,
  output logic           hs_data_en_o,
  output c2d_pkg::word_t hs_data_o
);

  typedef enum logic [2:0] {
    ST_LP11,
    ST_LP01,
    ST_LP00,
    ST_ZERO,
    ST_SYNC,
    ST_DATA,
    ST_TRAIL
  } lstate_t;

  lstate_t                     state_q;
  lstate_t                     state_d;
  logic [c2d_pkg::DWELL_W-1:0] cnt_q;  // Clocks spent in the current state
  c2d_pkg::word_t              last_q;  // Last word forwarded
  c2d_pkg::word_t              trail_word;

  ////////////////////////////////////////////////////////////////////////////
  // LP to HS sequence
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_LP11:  if (hs_req_i && cnt_q != '0) state_d = ST_LP01;  // One LP-11 clock after req
      ST_LP01:  if (cnt_q == c2d_pkg::LPX_END) state_d = ST_LP00;
      ST_LP00:  if (cnt_q == c2d_pkg::PREP_END) state_d = ST_ZERO;
      ST_ZERO:  if (cnt_q == c2d_pkg::ZERO_END) state_d = ST_SYNC;
      ST_SYNC:  state_d = ST_DATA;
      ST_DATA:  if (!hs_req_i) state_d = ST_TRAIL;
      ST_TRAIL: if (cnt_q == c2d_pkg::TRAIL_END) state_d = ST_LP11;
      default:  state_d = ST_LP11;
    endcase
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_LP11;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_d != state_q || (state_q == ST_LP11 && !hs_req_i)) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (state_q == ST_DATA && hs_req_i) begin
      last_q <= pkt_word_i;
    end
  end

  // Each lane holds the inverse of its final bit
  always_comb begin
    for (int l = 0; l < c2d_pkg::NUM_LANES; l++) begin
      trail_word[l*c2d_pkg::BYTE_W +: c2d_pkg::BYTE_W] =
        {c2d_pkg::BYTE_W{~last_q[l*c2d_pkg::BYTE_W + c2d_pkg::BYTE_W - 1]}};
    end
  end

  assign lp_p_o       = (state_q == ST_LP11);
  assign lp_n_o       = (state_q == ST_LP11) || (state_q == ST_LP01);
  assign hs_ack_o     = (state_q == ST_SYNC) || (state_q == ST_DATA) || (state_q == ST_TRAIL);
  assign hs_data_en_o = hs_ack_o || (state_q == ST_ZERO);

  always_comb begin
    case (state_q)
      ST_SYNC:  hs_data_o = {c2d_pkg::NUM_LANES{c2d_pkg::SYNC_BYTE}};
      ST_DATA:  hs_data_o = hs_req_i ? pkt_word_i : trail_word;  // Req low starts the trail
      ST_TRAIL: hs_data_o = trail_word;
      default:  hs_data_o = '0;  // HS zeros, or don't care in LP
    endcase
  end

endmodule

/* hdl/c2d_pixel2byte.sv */
`timescale 1ns/1ps

module c2d_pixel2byte (
  input  logic                       core_clk_i,
  input  logic                       rst_n_i,
  input  logic                       tinit_done_i,
  input  logic                       fv_i,
  input  logic                       lv_i,
  input  logic                       dvalid_i,
  input  logic [c2d_pkg::BYTE_W-1:0] pixdata_d1_i,
  input  logic [c2d_pkg::BYTE_W-1:0] pixdata_d0_i,
  output logic                       evt_push_o,
  output c2d_pkg::evt_kind_t         evt_o,
  output logic                       word_push_o,
  output c2d_pkg::word_t             word_o
);

  logic fv_q;
  logic lv_q;
  logic armed_q;  // Inside a frame that started after Tinit

  logic fv_rise;
  logic fv_fall;
  logic lv_fall;
  logic frame_start;

  assign fv_rise     = fv_i && !fv_q;
  assign fv_fall     = !fv_i && fv_q;
  assign lv_fall     = !lv_i && lv_q;
  assign frame_start = fv_rise && tinit_done_i;

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fv_q        <= 1'b0;
      lv_q        <= 1'b0;
      armed_q     <= 1'b0;
      evt_push_o  <= 1'b0;
      word_push_o <= 1'b0;
    end else begin
      fv_q <= fv_i;
      lv_q <= lv_i;
      if (frame_start) begin
        armed_q <= 1'b1;
      end else if (fv_fall) begin
        armed_q <= 1'b0;  // Frames that began before Tinit stay dropped
      end
      evt_push_o  <= frame_start || (armed_q && (fv_fall || lv_fall));
      word_push_o <= armed_q && lv_i && dvalid_i;
    end
  end

  // Sensor drops lv before fv, so the LINE and FE edges never coincide
  always_ff @(posedge core_clk_i) begin
    evt_o  <= fv_rise ? c2d_pkg::EVT_FS : (fv_fall ? c2d_pkg::EVT_FE : c2d_pkg::EVT_LINE);
    word_o <= {pixdata_d1_i, pixdata_d0_i};  // d0 is the first byte, lane 0
  end

endmodule

/* hdl/c2d_pkg.sv */
package c2d_pkg;

  // Lane and word geometry
  localparam int NUM_LANES = 2;
  localparam int BYTE_W    = 8;
  localparam int WORD_W    = NUM_LANES * BYTE_W;

  // Packet header fields
  localparam logic [1:0]  VC      = 2'd0;
  localparam logic [5:0]  DT_RAW8 = 6'h2A;
  localparam logic [5:0]  DT_FS   = 6'h00;
  localparam logic [5:0]  DT_FE   = 6'h01;
  localparam logic [15:0] WC      = 16'd36;  // Payload bytes per line

  localparam int                LINE_WORDS = int'(WC) / NUM_LANES;
  localparam int                BEAT_W     = $clog2(LINE_WORDS);
  localparam logic [BEAT_W-1:0] LAST_BEAT  = BEAT_W'(LINE_WORDS - 1);

  // Startup delay
  localparam int                 TINIT_CYCLES = 100;
  localparam int                 TINIT_W      = $clog2(TINIT_CYCLES + 1);
  localparam logic [TINIT_W-1:0] TINIT_END    = TINIT_W'(TINIT_CYCLES);

  // D-PHY line timing, in clocks
  localparam int                 T_LPX     = 4;
  localparam int                 T_PREPARE = 3;
  localparam int                 T_ZERO    = 6;
  localparam int                 T_TRAIL   = 4;
  localparam int                 DWELL_W   = 4;
  localparam logic [DWELL_W-1:0] LPX_END   = DWELL_W'(T_LPX - 1);
  localparam logic [DWELL_W-1:0] PREP_END  = DWELL_W'(T_PREPARE - 1);
  localparam logic [DWELL_W-1:0] ZERO_END  = DWELL_W'(T_ZERO - 1);
  localparam logic [DWELL_W-1:0] TRAIL_END = DWELL_W'(T_TRAIL - 2);  // First trail clock is in DATA

  localparam logic [BYTE_W-1:0] SYNC_BYTE = 8'hB8;

  localparam int FIFO_DEPTH = 32;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef logic [WORD_W-1:0] word_t;  // Lane 0 in the low byte

  typedef enum logic [1:0] {
    EVT_FS   = 2'd0,
    EVT_LINE = 2'd1,
    EVT_FE   = 2'd2
  } evt_kind_t;

endpackage

/* hdl/c2d_pkt_formatter.sv */
`timescale 1ns/1ps

module c2d_pkt_formatter (
  input  logic               core_clk_i,
  input  logic               rst_n_i,
  input  c2d_pkg::evt_kind_t evt_i,
  input  logic               evt_empty_i,
  output logic               evt_pop_o,
  input  c2d_pkg::word_t     word_i,
  input  logic               word_empty_i,
  output logic               word_pop_o,
  output logic               hs_req_o,
  input  logic               hs_ack_i,
  output c2d_pkg::word_t     pkt_word_o
);

  typedef enum logic [2:0] {
    F_IDLE,
    F_REQ,
    F_HDR0,
    F_HDR1,
    F_PAY,
    F_CRC,
    F_WAIT
  } fstate_t;

  fstate_t state_q;
  fstate_t state_d;

  logic [15:0]                frame_q;  // Frame number of the current frame
  logic [c2d_pkg::BEAT_W-1:0] beat_q;
  logic                       start_ok;

  // Header and CRC of the packet in flight
  logic [7:0]  di_q;
  logic [15:0] field_q;  // Word count or frame number
  logic        long_q;
  logic [15:0] crc_q;
  logic [7:0]  ecc;

  ////////////////////////////////////////////////////////////////////////////
  // Header ECC and payload CRC
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [5:0] ecc6(input logic [23:0] d);
    logic [5:0] p;
    p[0] = ^(d & 24'hF12CB7);
    p[1] = ^(d & 24'hF2555B);
    p[2] = ^(d & 24'h749A6D);
    p[3] = ^(d & 24'hB8E38E);
    p[4] = ^(d & 24'hDF03F0);
    p[5] = ^(d & 24'hEFFC00);
    return p;
  endfunction

  // Poly 0x1021 taken LSB first, hence the reflected constant
  function automatic logic [15:0] crc_byte(input logic [15:0] crc_in, input logic [7:0] data);
    logic [15:0] c;
    c = crc_in;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ 16'h8408;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  assign ecc = {2'b00, ecc6({field_q, di_q})};

  ////////////////////////////////////////////////////////////////////////////
  // Packet sequencing
  ////////////////////////////////////////////////////////////////////////////

  // A line is only started once its payload is buffered
  assign start_ok   = !evt_empty_i && ((evt_i != c2d_pkg::EVT_LINE) || !word_empty_i);
  assign evt_pop_o  = (state_q == F_IDLE) && start_ok;
  assign word_pop_o = (state_q == F_PAY) && !word_empty_i;
  assign hs_req_o   = (state_q != F_IDLE) && (state_q != F_WAIT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      F_IDLE: if (start_ok) state_d = F_REQ;
      F_REQ:  if (hs_ack_i) state_d = F_HDR0;
      F_HDR0: state_d = F_HDR1;
      F_HDR1: state_d = long_q ? F_PAY : F_WAIT;
      F_PAY:  if (word_pop_o && beat_q == c2d_pkg::LAST_BEAT) state_d = F_CRC;
      F_CRC:  state_d = F_WAIT;
      F_WAIT: if (!hs_ack_i) state_d = F_IDLE;  // Four-phase return
      default: state_d = F_IDLE;
    endcase
  end

  always_comb begin
    case (state_q)
      F_HDR0:  pkt_word_o = {field_q[7:0], di_q};
      F_HDR1:  pkt_word_o = {ecc, field_q[15:8]};
      F_PAY:   pkt_word_o = word_i;
      F_CRC:   pkt_word_o = crc_q;  // Low CRC byte on lane 0
      default: pkt_word_o = '0;
    endcase
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= F_IDLE;
      frame_q <= '0;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (evt_pop_o && evt_i == c2d_pkg::EVT_FS) begin
        frame_q <= frame_q + 1'b1;
      end
      if (state_q != F_PAY) begin
        beat_q <= '0;
      end else if (word_pop_o) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (evt_pop_o) begin
      long_q <= (evt_i == c2d_pkg::EVT_LINE);
      crc_q  <= 16'hFFFF;
      case (evt_i)
        c2d_pkg::EVT_FS: begin
          di_q    <= {c2d_pkg::VC, c2d_pkg::DT_FS};
          field_q <= frame_q + 1'b1;  // First frame is number 1
        end
        c2d_pkg::EVT_FE: begin
          di_q    <= {c2d_pkg::VC, c2d_pkg::DT_FE};
          field_q <= frame_q;
        end
        default: begin
          di_q    <= {c2d_pkg::VC, c2d_pkg::DT_RAW8};
          field_q <= c2d_pkg::WC;
        end
      endcase
    end else if (word_pop_o) begin
      crc_q <= crc_byte(crc_byte(crc_q, word_i[c2d_pkg::BYTE_W-1:0]),
                        word_i[c2d_pkg::WORD_W-1:c2d_pkg::BYTE_W]);
    end
  end

endmodule

/* hdl/c2d_startup.sv */
`timescale 1ns/1ps

module c2d_startup (
  input  logic core_clk_i,
  input  logic rst_n_i,
  output logic rst_n_o,
  output logic tinit_done_o
);

  logic [1:0]                  sync_q;
  logic [c2d_pkg::TINIT_W-1:0] tinit_cnt_q;

  // Asserts at once, releases on the second clock edge
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = sync_q[1];

  // Tinit counter stops once the delay is reached
  always_ff @(posedge core_clk_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      tinit_cnt_q <= '0;
    end else if (!tinit_done_o) begin
      tinit_cnt_q <= tinit_cnt_q + 1'b1;
    end
  end

  assign tinit_done_o = (tinit_cnt_q == c2d_pkg::TINIT_END);

endmodule

/* hdl/c2d_top.sv */
`timescale 1ns/1ps

module c2d_top (
  input  logic                       core_clk_i,
  input  logic                       rst_n_i,
  input  logic                       fv_i,
  input  logic                       lv_i,
  input  logic                       dvalid_i,
  input  logic [c2d_pkg::BYTE_W-1:0] pixdata_d1_i,
  input  logic [c2d_pkg::BYTE_W-1:0] pixdata_d0_i,
  output logic                       tinit_done_o,
  output logic                       lp_p_o,
  output logic                       lp_n_o,
  output logic                       hs_data_en_o,
  output c2d_pkg::word_t             hs_data_o,
  output logic                       d_hs_req_o,
  output logic                       d_hs_ack_o
);

  logic               core_rstn_w;  // Synchronized reset for all logic
  logic               evt_push_w;
  c2d_pkg::evt_kind_t evt_in_w;
  c2d_pkg::evt_kind_t evt_out_w;
  logic               evt_empty_w;
  logic               evt_pop_w;
  logic               word_push_w;
  c2d_pkg::word_t     word_in_w;
  c2d_pkg::word_t     word_out_w;
  logic               word_empty_w;
  logic               word_pop_w;
  c2d_pkg::word_t     pkt_word_w;

  ////////////////////////////////////////////////////////////////////////////
  // Reset and pixel side
  ////////////////////////////////////////////////////////////////////////////

  c2d_startup i_startup (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (rst_n_i),
    .rst_n_o      (core_rstn_w),
    .tinit_done_o (tinit_done_o)
  );

  c2d_pixel2byte i_pixel2byte (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (core_rstn_w),
    .tinit_done_i (tinit_done_o),
    .fv_i         (fv_i),
    .lv_i         (lv_i),
    .dvalid_i     (dvalid_i),
    .pixdata_d1_i (pixdata_d1_i),
    .pixdata_d0_i (pixdata_d0_i),
    .evt_push_o   (evt_push_w),
    .evt_o        (evt_in_w),
    .word_push_o  (word_push_w),
    .word_o       (word_in_w)
  );

  // Frame and line events
  c2d_fifo #(.payload_t(c2d_pkg::evt_kind_t)) i_evt_fifo (
    .core_clk_i (core_clk_i),
    .rst_n_i    (core_rstn_w),
    .push_i     (evt_push_w),
    .data_i     (evt_in_w),
    .pop_i      (evt_pop_w),
    .data_o     (evt_out_w),
    .empty_o    (evt_empty_w),
    .full_o     ()
  );

  // Payload words
  c2d_fifo #(.payload_t(c2d_pkg::word_t)) i_word_fifo (
    .core_clk_i (core_clk_i),
    .rst_n_i    (core_rstn_w),
    .push_i     (word_push_w),
    .data_i     (word_in_w),
    .pop_i      (word_pop_w),
    .data_o     (word_out_w),
    .empty_o    (word_empty_w),
    .full_o     ()
  );

  ////////////////////////////////////////////////////////////////////////////
  // Packet and lane side
  ////////////////////////////////////////////////////////////////////////////

  c2d_pkt_formatter i_formatter (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (core_rstn_w),
    .evt_i        (evt_out_w),
    .evt_empty_i  (evt_empty_w),
    .evt_pop_o    (evt_pop_w),
    .word_i       (word_out_w),
    .word_empty_i (word_empty_w),
    .word_pop_o   (word_pop_w),
    .hs_req_o     (d_hs_req_o),
    .hs_ack_i     (d_hs_ack_o),
    .pkt_word_o   (pkt_word_w)
  );

  c2d_lane_ctrl i_lane_ctrl (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (core_rstn_w),
    .hs_req_i     (d_hs_req_o),
    .hs_ack_o     (d_hs_ack_o),
    .pkt_word_i   (pkt_word_w),
    .lp_p_o       (lp_p_o),
    .lp_n_o       (lp_n_o),
    .hs_data_en_o (hs_data_en_o),
    .hs_data_o    (hs_data_o)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the CSI-2 transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module c2d_tb --Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vc2d_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
echo "Simulation finished"
exit 0

/* tests/c2d_properties.sv */
`timescale 1ns/1ps

module c2d_properties (
  input logic core_clk_i,
  input logic rst_n_i,
  input logic hs_req_i,
  input logic hs_ack_i,
  input logic lp_p_i,
  input logic lp_n_i,
  input logic hs_data_en_i
);

  // HS drive only with both LP lines low
  hs_needs_lp00: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    hs_data_en_i |-> (!lp_p_i && !lp_n_i))
    else $error("hs_data_en high while an LP line is high");

  ack_needs_req: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    $rose(hs_ack_i) |-> hs_req_i)
    else $error("hs_ack rose without a pending hs_req");

  // Trail ends back in LP-11
  stop_to_lp11: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    $fell(hs_req_i) |-> ##(c2d_pkg::T_TRAIL) (lp_p_i && lp_n_i))
    else $error("lane did not return to LP-11 after hs_req dropped");

endmodule

bind c2d_lane_ctrl c2d_properties i_properties (
  .core_clk_i   (core_clk_i),
  .rst_n_i      (rst_n_i),
  .hs_req_i     (hs_req_i),
  .hs_ack_i     (hs_ack_o),
  .lp_p_i       (lp_p_o),
  .lp_n_i       (lp_n_o),
  .hs_data_en_i (hs_data_en_o)
);

/* tests/c2d_tb.sv */
`timescale 1ns/1ps

module c2d_tb;

  localparam int FRAMES          = 5;
  localparam int LINES           = 4;
  localparam int ACK_LAT         = c2d_pkg::T_LPX + c2d_pkg::T_PREPARE + c2d_pkg::T_ZERO + 2;
  localparam int WATCHDOG_CYCLES = c2d_pkg::TINIT_CYCLES + FRAMES * LINES * 200 + 2000;

  logic                       core_clk;
  logic                       rst_n;
  logic                       fv;
  logic                       lv;
  logic                       dvalid;
  logic [c2d_pkg::BYTE_W-1:0] pix_d1;
  logic [c2d_pkg::BYTE_W-1:0] pix_d0;
  logic                       tinit_done;
  logic                       lp_p;
  logic                       lp_n;
  logic                       hs_data_en;
  c2d_pkg::word_t             hs_data;
  logic                       hs_req;
  logic                       hs_ack;

  logic [31:0] lfsr_state = 32'hc84f;
  logic [7:0]  exp_q[$];  // Expected HS bytes in lane order
  int          bursts_seen = 0;

  c2d_top i_dut (
    .core_clk_i   (core_clk),
    .rst_n_i      (rst_n),
    .fv_i         (fv),
    .lv_i         (lv),
    .dvalid_i     (dvalid),
    .pixdata_d1_i (pix_d1),
    .pixdata_d0_i (pix_d0),
    .tinit_done_o (tinit_done),
    .lp_p_o       (lp_p),
    .lp_n_o       (lp_n),
    .hs_data_en_o (hs_data_en),
    .hs_data_o    (hs_data),
    .d_hs_req_o   (hs_req),
    .d_hs_ack_o   (hs_ack)
  );

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error handling and random numbers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_value(input string name, input int got, input int want);
    assert (got == want) else
      fail_run($sformatf("CHECK FAILED at time %0t: %s = 0x%0h, expected 0x%0h",
                         $time, name, got, want));
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int blank_len();
    return 60 + int'(next_bits(6) % 32'd61);  // 60 to 120 clocks
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // CSI-2 header Hamming code with D0 as bit 0 of the data identifier
  function automatic logic [7:0] hdr_ecc(input logic [23:0] d);
    logic [7:0] e;
    e    = '0;
    e[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
    e[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
    e[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
    e[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
    e[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
    e[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
    return e;
  endfunction

  // Serial x^16+x^12+x^5+1 register with data bits entering LSB first
  function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb    = c[0] ^ b[i];
      c     = {fb, c[15:1]};
      c[10] = c[10] ^ fb;
      c[3]  = c[3] ^ fb;
    end
    return c;
  endfunction

  task automatic push_header(input logic [5:0] dt, input logic [15:0] field);
    logic [7:0] di;
    di = {c2d_pkg::VC, dt};
    exp_q.push_back(di);
    exp_q.push_back(field[7:0]);
    exp_q.push_back(field[15:8]);
    exp_q.push_back(hdr_ecc({field, di}));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_clk();
    @(posedge core_clk);
    #10;
  endtask

  task automatic drive_line();
    logic [7:0]  pay[$];
    logic [15:0] crc;
    logic        dv;
    lv = 1'b1;
    while (pay.size() < int'(c2d_pkg::WC)) begin
      dv     = (next_bits(2) != 0);  // About one gap in four
      dvalid = dv;
      pix_d0 = 8'(next_bits(8));
      pix_d1 = 8'(next_bits(8));
      if (dv) begin
        pay.push_back(pix_d0);
        pay.push_back(pix_d1);
      end
      step_clk();
    end
    lv     = 1'b0;
    dvalid = 1'b0;
    push_header(c2d_pkg::DT_RAW8, c2d_pkg::WC);
    crc = 16'hFFFF;
    foreach (pay[i]) begin
      exp_q.push_back(pay[i]);
      crc = crc16_update(crc, pay[i]);
    end
    exp_q.push_back(crc[7:0]);  // Low byte first
    exp_q.push_back(crc[15:8]);
  endtask

  task automatic drive_frame(input int fnum);
    logic [15:0] fn;
    fn = 16'(fnum);
    push_header(c2d_pkg::DT_FS, fn);
    fv = 1'b1;
    repeat (10) step_clk();
    for (int l = 0; l < LINES; l++) begin
      drive_line();
      repeat (blank_len()) step_clk();
    end
    fv = 1'b0;
    push_header(c2d_pkg::DT_FE, fn);
    repeat (blank_len()) step_clk();
  endtask

  // Frame that opens during Tinit and must be dropped whole
  task automatic drive_early_frame();
    repeat (5) step_clk();
    fv = 1'b1;
    repeat (5) step_clk();
    lv     = 1'b1;
    dvalid = 1'b1;
    repeat (c2d_pkg::LINE_WORDS) begin
      pix_d0 = 8'(next_bits(8));
      pix_d1 = 8'(next_bits(8));
      step_clk();
    end
    lv     = 1'b0;
    dvalid = 1'b0;
    while (!tinit_done) step_clk();
    repeat (10) step_clk();
    fv = 1'b0;
    repeat (60) step_clk();
  endtask

  task automatic check_startup();
    int edges;
    edges = 0;
    while (!tinit_done) begin
      @(posedge core_clk);
      #1;
      edges++;
      assert (!hs_data_en) else fail_run("HS output was enabled before Tinit completed");
      assert (edges <= c2d_pkg::TINIT_CYCLES + 10) else fail_run("tinit_done_o never rose");
    end
    expect_value("tinit_done_o delay", edges, c2d_pkg::TINIT_CYCLES + 2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_byte(input logic [7:0] got, input int lane, output logic [7:0] want);
    assert (exp_q.size() != 0) else fail_run("HS byte arrived while no packet was expected");
    want = exp_q.pop_front();
    expect_value($sformatf("hs_data_o lane %0d", lane), int'(got), int'(want));
  endtask

  // Entered on the first HS-zero clock of a burst
  task automatic collect_burst();
    logic [31:0] hdr;
    logic [7:0]  rx_byte;
    logic [7:0]  exp_byte;
    logic [15:0] last_exp;  // Last expected word, lane 0 low
    logic [15:0] trail_want;
    int          zeros;
    int          total;
    int          nbytes;
    int          trail;
    zeros    = 0;
    last_exp = '0;
    while (hs_data_en && hs_data == '0) begin
      zeros++;
      @(negedge core_clk);
    end
    expect_value("HS zero clocks", zeros, c2d_pkg::T_ZERO);
    expect_value("hs_data_o sync", int'(hs_data), int'({2{c2d_pkg::SYNC_BYTE}}));
    bursts_seen++;
    hdr    = '0;
    nbytes = 0;
    total  = 4;
    while (nbytes < total) begin
      @(negedge core_clk);
      expect_value("hs_data_en_o", int'(hs_data_en), 1);
      for (int l = 0; l < c2d_pkg::NUM_LANES; l++) begin
        rx_byte = hs_data[l*8 +: 8];
        if (nbytes < 4) hdr[nbytes*8 +: 8] = rx_byte;
        expect_byte(rx_byte, l, exp_byte);
        last_exp[l*8 +: 8] = exp_byte;
        nbytes++;
      end
      if (nbytes == 4 && hdr[5:0] >= 6'h10) total = 4 + int'(hdr[23:8]) + 2;  // Long packet
    end
    trail_want = {{8{~last_exp[15]}}, {8{~last_exp[7]}}};
    trail      = 0;
    @(negedge core_clk);
    while (hs_data_en) begin
      expect_value("hs_data_o trail", int'(hs_data), int'(trail_want));
      trail++;
      @(negedge core_clk);
    end
    expect_value("HS trail clocks", trail, c2d_pkg::T_TRAIL);
  endtask

  initial begin : burst_monitor
    forever begin
      @(negedge core_clk);
      if (hs_data_en) collect_burst();
    end
  end

  initial begin : handshake_timing
    int   cyc;
    int   req_cyc;
    logic req_prev;
    logic ack_prev;
    cyc      = 0;
    req_cyc  = 0;
    req_prev = 1'b0;
    ack_prev = 1'b0;
    forever begin
      @(negedge core_clk);
      cyc++;
      if (hs_req && !req_prev) req_cyc = cyc;
      if (hs_ack && !ack_prev) expect_value("d_hs_ack_o latency", cyc - req_cyc, ACK_LAT);
      req_prev = hs_req;
      ack_prev = hs_ack;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge core_clk);
    fail_run("Watchdog expired before all packets were received");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    fv     = 1'b0;
    lv     = 1'b0;
    dvalid = 1'b0;
    pix_d0 = '0;
    pix_d1 = '0;
    rst_n  = 1'b0;
    repeat (16) @(posedge core_clk);
    #10;
    rst_n = 1'b1;
    fork
      check_startup();
      drive_early_frame();
    join
    assert (bursts_seen == 0) else fail_run("A frame begun before Tinit produced HS output");
    for (int f = 1; f <= FRAMES; f++) begin
      drive_frame(f);
    end
    while (exp_q.size() != 0) step_clk();
    repeat (20) step_clk();
    if (lp_p && lp_n && !hs_data_en) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run("Lanes did not return to LP-11 at the end of the run");
    end
  end

endmodule
